/* files.f */
logic/gen_bus_pkg.sv
logic/gen_dsp_pkg.sv
logic/gen_regs.sv
logic/gen_chan.sv
logic/gen_mixer.sv
logic/gen_top.sv
sim/gen_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the waveform generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module gen_tb -f files.f -o gen_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/gen_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF '** PASS **'; then
  exit 0
fi
exit 1

/* sim/gen_tb.sv */
// testbench for the two channel waveform generator
// drives AXI4-Lite register and table writes, models each channel and
// the mixer on integers, and checks readback, dac samples, status, irq
`timescale 1ns/1ps
`default_nettype none

module gen_tb;
  import gen_bus_pkg::*;
  import gen_dsp_pkg::*;

  localparam int CLK_PERIOD  = 10;
  // planned sample counts per test
  localparam int N_CONT      = 300;
  localparam int N_BURST_MAX = 80;
  localparam int N_MIX_MAX   = 100;
  // bus transfers and the cycle allowance for each
  localparam int N_XFER      = 160;
  localparam int XFER_MARGIN = 40;
  localparam int WD_CYCLES   = N_CONT + N_BURST_MAX + N_MIX_MAX + N_XFER * XFER_MARGIN;
  localparam int HS_LIMIT    = 32;
  // DAC range
  localparam int S_MAX       = 8191;
  localparam int S_MIN       = -8192;
  // addresses with nothing behind them
  localparam addr_t HOLES [6] = '{12'h00c, 12'h014, 12'h034, 12'h060, 12'h100, 12'hffc};

  logic    bus;
  logic    rst_n;
  logic    awvalid;
  addr_t   awaddr;
  logic    awready;
  logic    wvalid;
  data_t   wdata;
  logic    wready;
  logic    bvalid;
  logic    bready;
  resp_t   bresp;
  logic    arvalid;
  addr_t   araddr;
  logic    arready;
  logic    rvalid;
  data_t   rdata;
  resp_t   rresp;
  logic    rready;
  sample_t dac;
  logic    dac_vld;
  logic    irq;

  logic [31:0] lfsr;
  int          err_cnt;
  int          fail_cnt;
  // captured dac stream and model streams
  sample_t     got_q [$];
  int          exp_q [$];
  int          chq [$];
  int          q0 [$];
  int          q1 [$];
  // model copy of the channel settings
  int          m_step [NCH];
  int          m_ph0  [NCH];
  int          m_gain [NCH];
  int          m_dc   [NCH];
  int          m_cyc  [NCH];
  int          m_tbl  [NCH][16];

  gen_top DUT (
    .bus     (bus),
    .rst_n   (rst_n),
    .awvalid (awvalid),
    .awaddr  (awaddr),
    .awready (awready),
    .wvalid  (wvalid),
    .wdata   (wdata),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .araddr  (araddr),
    .arready (arready),
    .rvalid  (rvalid),
    .rdata   (rdata),
    .rresp   (rresp),
    .rready  (rready),
    .dac     (dac),
    .dac_vld (dac_vld),
    .irq     (irq)
  );

  initial begin
    bus = 1'b0;
    forever #(CLK_PERIOD / 2) bus = ~bus;
  end

  // hard stop in case a test hangs
  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the tests did not finish", WD_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  // collect every valid dac sample on the falling edge
  always @(negedge bus) begin
    if (rst_n && dac_vld)
      got_q.push_back(dac);
  end

  //////////////////////////////////////////////////////////////////////
  // random numbers and model
  //////////////////////////////////////////////////////////////////////

  // fibonacci lfsr with taps 32 22 2 1, stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // low w bits as a signed value
  function automatic int sext(input int v, input int w);
    int m;
    m = v & ((1 << w) - 1);
    if (m >= (1 << (w - 1)))
      m = m - (1 << w);
    return m;
  endfunction

  function automatic int sat14(input int v);
    if (v > S_MAX)
      return S_MAX;
    if (v < S_MIN)
      return S_MIN;
    return v;
  endfunction

  // sample times Q1.14 gain rounded down, plus dc and clamped
  function automatic int xform(input int s, input int g, input int d);
    int p;
    p = (s * g) >>> 14;
    return sat14(p + d);
  endfunction

  // gain magnitude between 1.5 and 2
  function automatic int big_gain();
    int r;
    r = int'(rand_bits(13));
    if (rand_bits(1) != 0)
      return 24576 + r;
    return -32768 + r;
  endfunction

  // one sample per addressed cycle until the last wrap of a burst
  task automatic model_chan(input int c, input int n_max);
    int ph;
    int nxt;
    int wraps;
    bit last;
    chq.delete();
    ph    = m_ph0[c];
    wraps = 0;
    last  = 1'b0;
    chq.push_back(xform(m_tbl[c][ph >> 8], m_gain[c], m_dc[c]));
    while (!last && chq.size() < n_max) begin
      nxt = ph + m_step[c];
      ph  = nxt % 4096;
      if (nxt >= 4096) begin
        wraps++;
        if (m_cyc[c] != 0 && wraps == m_cyc[c])
          last = 1'b1;
      end
      chq.push_back(xform(m_tbl[c][ph >> 8], m_gain[c], m_dc[c]));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus tasks start and end 1 ns after a rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic next_edge();
    @(posedge bus);
    #1;
  endtask

  task automatic settle(input int n);
    repeat (n) next_edge();
  endtask

  task automatic axi_write(input addr_t a, input data_t d);
    int n;
    int hold;
    // sometimes stall the response
    hold    = (rand_bits(1) != 0) ? int'(rand_bits(3)) : 0;
    awaddr  = a;
    wdata   = d;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    @(negedge bus);
    while (!(awready && wready) && n < HS_LIMIT) begin
      @(negedge bus);
      n++;
    end
    if (!(awready && wready)) begin
      $display("t=%0t write to %h was never accepted", $time, a);
      fail_cnt++;
    end
    next_edge();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    settle(hold);
    bready = 1'b1;
    n = 0;
    @(negedge bus);
    while (!bvalid && n < HS_LIMIT) begin
      @(negedge bus);
      n++;
    end
    if (!bvalid || bresp != RESP_OKAY) begin
      $display("t=%0t write to %h got no OKAY response", $time, a);
      fail_cnt++;
    end
    next_edge();
    bready = 1'b0;
  endtask

  task automatic axi_read(input addr_t a, output data_t d);
    int n;
    araddr  = a;
    arvalid = 1'b1;
    n = 0;
    @(negedge bus);
    while (!arready && n < HS_LIMIT) begin
      @(negedge bus);
      n++;
    end
    if (!arready) begin
      $display("t=%0t read of %h was never accepted", $time, a);
      fail_cnt++;
    end
    next_edge();
    arvalid = 1'b0;
    rready  = 1'b1;
    n = 0;
    @(negedge bus);
    while (!rvalid && n < HS_LIMIT) begin
      @(negedge bus);
      n++;
    end
    if (!rvalid || rresp != RESP_OKAY) begin
      $display("t=%0t read of %h got no OKAY data", $time, a);
      fail_cnt++;
    end
    d = rdata;
    next_edge();
    rready = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_dac(input int idx, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t dac[%0d] got=%0d exp=%0d", $time, idx, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_irq(input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t irq got=%b exp=%b", $time, got, exp);
      err_cnt++;
    end
  endtask

  task automatic read_check(input addr_t a, input data_t exp, input string name);
    data_t d;
    axi_read(a, d);
    check_data(name, d, exp);
  endtask

  task automatic compare_stream(input int n);
    for (int k = 0; k < n && k < got_q.size(); k++)
      check_dac(k, got_q[k], sample_t'(exp_q[k]));
  endtask

  // bounded wait for n captured samples
  task automatic wait_samples(input int n, input int limit);
    int k;
    k = 0;
    while (got_q.size() < n && k < limit) begin
      next_edge();
      k++;
    end
    if (got_q.size() < n) begin
      $display("t=%0t only %0d of %0d dac samples arrived", $time, got_q.size(), n);
      fail_cnt++;
    end
  endtask

  // write the five channel registers and keep the model in step
  task automatic config_chan(input int c, input int st, input int ph, input int g,
                             input int d, input int cyc);
    addr_t b;
    b = addr_t'(int'(CH_BASE) + c * int'(CH_STRIDE));
    axi_write(b + CH_STEP, data_t'(st));
    axi_write(b + CH_PHASE, data_t'(ph));
    axi_write(b + CH_GAIN, data_t'(g));
    axi_write(b + CH_DC, data_t'(d));
    axi_write(b + CH_CYC, data_t'(cyc));
    m_step[c] = st & 'hfff;
    m_ph0[c]  = ph & 'hfff;
    m_gain[c] = sext(g, 16);
    m_dc[c]   = sext(d, 14);
    m_cyc[c]  = cyc & 'hffff;
  endtask

  // random table with junk in the upper word bits
  task automatic load_table(input int c);
    data_t d;
    for (int i = 0; i < 16; i++) begin
      d = rand_bits(32);
      axi_write(addr_t'(int'(TBL_BASE) + c * int'(TBL_STRIDE) + 4 * i), d);
      m_tbl[c][i] = sext(int'(d), 14);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  initial begin
    data_t v;
    addr_t a;
    data_t fmask;
    int    st;
    int    cyc;
    int    p0;
    int    p1;
    int    n;
    int    n_exp;
    lfsr     = 32'h938b;
    err_cnt  = 0;
    fail_cnt = 0;
    rst_n    = 1'b0;
    awvalid  = 1'b0;
    awaddr   = '0;
    wvalid   = 1'b0;
    wdata    = '0;
    bready   = 1'b0;
    arvalid  = 1'b0;
    araddr   = '0;
    rready   = 1'b0;
    repeat (5) @(posedge bus);
    #1;
    rst_n = 1'b1;
    next_edge();

    // register readback of every channel field and the mask
    for (int c = 0; c < NCH; c++) begin
      for (int r = 0; r < 5; r++) begin
        v = rand_bits(32);
        a = addr_t'(int'(CH_BASE) + c * int'(CH_STRIDE) + 4 * r);
        // step, phase 12 bits, gain 16, dc 14, cycles 16
        fmask = (r < 2) ? 32'hfff : ((r == 3) ? 32'h3fff : 32'hffff);
        axi_write(a, v);
        read_check(a, v & fmask, $sformatf("ch%0d reg +%0h", c, 4 * r));
      end
    end
    v = rand_bits(32);
    axi_write(REG_IRQ_EN, v);
    read_check(REG_IRQ_EN, v & data_t'((1 << NCH) - 1), "irq mask");
    for (int i = 0; i < 6; i++)
      read_check(HOLES[i], '0, $sformatf("unmapped %h", HOLES[i]));

    // single channel in continuous mode
    load_table(0);
    st = 16 + int'(rand_bits(9));
    config_chan(0, st, int'(rand_bits(12)), int'(rand_bits(16)), int'(rand_bits(14)), 0);
    model_chan(0, N_CONT);
    exp_q = chq;
    got_q.delete();
    axi_write(REG_CTRL, 32'h1);
    wait_samples(N_CONT, N_CONT + 40);
    compare_stream(N_CONT);
    axi_write(REG_CTRL, 32'h0);
    // pipeline drains after disable
    n = 0;
    @(negedge bus);
    while (dac_vld && n < 8) begin
      @(negedge bus);
      n++;
    end
    if (dac_vld) begin
      $display("t=%0t dac_vld still high 8 cycles after disable", $time);
      fail_cnt++;
    end
    next_edge();

    // burst of a few table periods
    load_table(0);
    st  = 256 + int'(rand_bits(10));
    cyc = 1 + int'(rand_bits(2));
    config_chan(0, st, int'(rand_bits(12)), int'(rand_bits(16)), int'(rand_bits(14)), cyc);
    model_chan(0, 4 * N_BURST_MAX);
    exp_q = chq;
    axi_write(REG_IRQ_EN, 32'h1);
    got_q.delete();
    axi_write(REG_CTRL, 32'h1);
    wait_samples(exp_q.size(), exp_q.size() + 40);
    settle(10);
    check_data("burst dac_vld count", data_t'(got_q.size()), data_t'(exp_q.size()));
    compare_stream(exp_q.size());
    read_check(REG_STAT, 32'h1, "stat after burst");
    read_check(REG_CTRL, 32'h0, "enable after burst");
    check_irq(irq, 1'b1);
    axi_write(REG_IRQ_EN, 32'h0);
    settle(2);
    check_irq(irq, 1'b0);
    axi_write(REG_IRQ_EN, 32'h1);
    settle(2);
    check_irq(irq, 1'b1);

    // writing 1 clears the done bit and writing 0 keeps it
    axi_write(REG_STAT, 32'h0);
    read_check(REG_STAT, 32'h1, "stat after writing 0");
    settle(2);
    check_irq(irq, 1'b1);
    axi_write(REG_STAT, 32'h1);
    read_check(REG_STAT, 32'h0, "stat after writing 1");
    settle(2);
    check_irq(irq, 1'b0);

    // two channels mixed with the same step
    // channel 1 starts no later in phase and needs more wraps, so it runs longer
    load_table(0);
    load_table(1);
    st  = 256 + int'(rand_bits(9));
    cyc = 1 + int'(rand_bits(2));
    p0  = int'(rand_bits(12));
    p1  = int'(rand_bits(12)) % (p0 + 1);
    config_chan(0, st, p0, big_gain(), int'(rand_bits(14)), cyc);
    config_chan(1, st, p1, big_gain(), int'(rand_bits(14)), cyc + 1 + int'(rand_bits(1)));
    model_chan(0, 4 * N_MIX_MAX);
    q0 = chq;
    model_chan(1, 4 * N_MIX_MAX);
    q1 = chq;
    n_exp = (q0.size() > q1.size()) ? q0.size() : q1.size();
    exp_q.delete();
    for (int k = 0; k < n_exp; k++)
      exp_q.push_back(sat14(((k < q0.size()) ? q0[k] : 0) + ((k < q1.size()) ? q1[k] : 0)));
    got_q.delete();
    axi_write(REG_CTRL, 32'h3);
    wait_samples(n_exp, n_exp + 40);
    settle(10);
    check_data("mixed dac_vld count", data_t'(got_q.size()), data_t'(n_exp));
    compare_stream(n_exp);
    read_check(REG_STAT, 32'h3, "stat after both bursts");
    read_check(REG_CTRL, 32'h0, "enables after both bursts");

    $display("checks done: %0d mismatches, %0d other errors", err_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

/* logic/gen_top.sv */
// two channel arbitrary waveform generator
// register block, one generator per channel and the output mixer
`timescale 1ns/1ps
`default_nettype none

module gen_top (
  input  logic                 bus,
  input  logic                 rst_n,
  // AXI4-Lite slave
  input  logic                 awvalid,
  input  gen_bus_pkg::addr_t   awaddr,
  output logic                 awready,
  input  logic                 wvalid,
  input  gen_bus_pkg::data_t   wdata,
  output logic                 wready,
  output logic                 bvalid,
  input  logic                 bready,
  output gen_bus_pkg::resp_t   bresp,
  input  logic                 arvalid,
  input  gen_bus_pkg::addr_t   araddr,
  output logic                 arready,
  output logic                 rvalid,
  output gen_bus_pkg::data_t   rdata,
  output gen_bus_pkg::resp_t   rresp,
  input  logic                 rready,
  // DAC and interrupt
  output gen_dsp_pkg::sample_t dac,
  output logic                 dac_vld,
  output logic                 irq
);
  import gen_dsp_pkg::*;

  // per-channel settings
  logic [NCH-1:0] run;
  logic [NCH-1:0] done;
  phase_t         step   [NCH];
  phase_t         phase0 [NCH];
  gain_t          gain   [NCH];
  sample_t        dc     [NCH];
  cycles_t        cycles [NCH];
  // table write port
  logic [NCH-1:0] tbl_we;
  tbl_addr_t      tbl_addr;
  sample_t        tbl_data;
  // channel outputs
  sample_t        smp    [NCH];
  logic [NCH-1:0] smp_vld;

  gen_regs u_regs (
    .bus      (bus),
    .rst_n    (rst_n),
    .awvalid  (awvalid),
    .awaddr   (awaddr),
    .awready  (awready),
    .wvalid   (wvalid),
    .wdata    (wdata),
    .wready   (wready),
    .bvalid   (bvalid),
    .bready   (bready),
    .bresp    (bresp),
    .arvalid  (arvalid),
    .araddr   (araddr),
    .arready  (arready),
    .rvalid   (rvalid),
    .rdata    (rdata),
    .rresp    (rresp),
    .rready   (rready),
    .done     (done),
    .run      (run),
    .step     (step),
    .phase0   (phase0),
    .gain     (gain),
    .dc       (dc),
    .cycles   (cycles),
    .tbl_we   (tbl_we),
    .tbl_addr (tbl_addr),
    .tbl_data (tbl_data),
    .irq      (irq)
  );

  // one generator per channel
  for (genvar i = 0; i < NCH; i++) begin : g_chan
    gen_chan u_chan (
      .bus      (bus),
      .rst_n    (rst_n),
      .run      (run[i]),
      .step     (step[i]),
      .phase0   (phase0[i]),
      .gain     (gain[i]),
      .dc       (dc[i]),
      .cycles   (cycles[i]),
      .tbl_we   (tbl_we[i]),
      .tbl_addr (tbl_addr),
      .tbl_data (tbl_data),
      .smp      (smp[i]),
      .smp_vld  (smp_vld[i]),
      .done     (done[i])
    );
  end

  gen_mixer u_mixer (
    .bus     (bus),
    .rst_n   (rst_n),
    .smp     (smp),
    .smp_vld (smp_vld),
    .dac     (dac),
    .dac_vld (dac_vld)
  );

endmodule

`default_nettype wire

/* logic/gen_mixer.sv */
// channel mixer
// adds the valid channel samples, clamps to the 14-bit DAC range and
// registers the result with its strobe
`timescale 1ns/1ps
`default_nettype none

module gen_mixer (
  input  logic                          bus,
  input  logic                          rst_n,
  input  gen_dsp_pkg::sample_t          smp [gen_dsp_pkg::NCH],
  input  logic [gen_dsp_pkg::NCH-1:0]   smp_vld,
  output gen_dsp_pkg::sample_t          dac,
  output logic                          dac_vld
);
  import gen_dsp_pkg::*;

  logic signed [MIX_W-1:0] acc;
  sample_t                 sat;

  // idle channels count as zero
  always_comb begin
    acc = '0;
    for (int i = 0; i < NCH; i++) begin
      if (smp_vld[i])
        acc = acc + MIX_W'(smp[i]);
    end
  end

  // clamp to the DAC range
  always_comb begin
    if (acc > MIX_W'(SMP_MAX))
      sat = SMP_MAX;
    else if (acc < MIX_W'(SMP_MIN))
      sat = SMP_MIN;
    else
      sat = sample_t'(acc);
  end

  always_ff @(posedge bus) begin
    dac <= sat;
  end

  // strobe when any channel delivered
  always_ff @(posedge bus) begin
    if (!rst_n)
      dac_vld <= 1'b0;
    else
      dac_vld <= |smp_vld;
  end

endmodule

`default_nettype wire

/* logic/gen_chan.sv */
// one waveform generator channel
// table memory, phase accumulator with burst period counter, and a
// three stage pipeline computing sat(table * gain + dc)
`timescale 1ns/1ps
`default_nettype none

module gen_chan (
  input  logic                   bus,
  input  logic                   rst_n,
  input  logic                   run,
  input  gen_dsp_pkg::phase_t    step,
  input  gen_dsp_pkg::phase_t    phase0,
  input  gen_dsp_pkg::gain_t     gain,
  input  gen_dsp_pkg::sample_t   dc,
  input  gen_dsp_pkg::cycles_t   cycles,
  input  logic                   tbl_we,
  input  gen_dsp_pkg::tbl_addr_t tbl_addr,
  input  gen_dsp_pkg::sample_t   tbl_data,
  output gen_dsp_pkg::sample_t   smp,
  output logic                   smp_vld,
  output logic                   done
);
  import gen_dsp_pkg::*;

  sample_t                   tbl [2**TBL_AW];
  // phase control
  logic                      run_q;
  logic                      halted;
  logic                      first;
  logic                      act;
  logic                      wrap;
  logic [PH_W:0]             ph_sum;
  phase_t                    ph;
  phase_t                    ph_cur;
  tbl_addr_t                 rd_idx;
  cycles_t                   wraps;
  // pipeline
  sample_t                   rd_smp;
  logic                      rd_vld;
  logic signed [SMP_W+GAIN_W-1:0] prod;
  logic signed [MUL_W-1:0]   mul_q;
  logic                      mul_vld;
  logic signed [ACC_W-1:0]   sum;
  sample_t                   sat;

  // waveform table, written from the bus
  always_ff @(posedge bus) begin
    if (tbl_we)
      tbl[tbl_addr] <= tbl_data;
  end

  //////////////////////////////////////////////////////////////////////
  // phase accumulator
  //////////////////////////////////////////////////////////////////////

  // rising edge of run restarts from phase0
  assign first  = run & ~run_q;
  // no addressing once the burst is over
  assign act    = run & ~halted;
  assign ph_sum = {1'b0, ph} + {1'b0, step};
  // carry out of the 12-bit add
  assign wrap   = ph_sum[PH_W] & ~first;
  assign ph_cur = first ? phase0 : ph_sum[PH_W-1:0];
  // integer part picks the entry
  assign rd_idx = ph_cur[PH_W-1:PH_FW];

  // last wrap of a burst, that cycle's sample still goes out
  assign done = act & wrap & (cycles != '0) & (cycles_t'(wraps + 1'b1) == cycles);

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      run_q  <= 1'b0;
      halted <= 1'b0;
      ph     <= '0;
      wraps  <= '0;
    end else begin
      run_q <= run;
      if (!run)
        halted <= 1'b0;
      else if (done)
        halted <= 1'b1;
      if (act)
        ph <= ph_cur;
      // period counter
      if (first)
        wraps <= '0;
      else if (act && wrap)
        wraps <= wraps + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // transform pipeline
  //////////////////////////////////////////////////////////////////////

  assign prod = rd_smp * gain;
  // sign extend both terms before adding dc
  assign sum  = ACC_W'(mul_q) + ACC_W'(dc);

  always_comb begin
    if (sum > ACC_W'(SMP_MAX))
      sat = SMP_MAX;
    else if (sum < ACC_W'(SMP_MIN))
      sat = SMP_MIN;
    else
      sat = sample_t'(sum);
  end

  // data stages
  always_ff @(posedge bus) begin
    rd_smp <= tbl[rd_idx];
    // drop the Q14 fraction
    mul_q  <= MUL_W'(prod >>> GAIN_FW);
    smp    <= sat;
  end

  // valid stages, drain after run falls
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      rd_vld  <= 1'b0;
      mul_vld <= 1'b0;
      smp_vld <= 1'b0;
    end else begin
      rd_vld  <= act;
      mul_vld <= rd_vld;
      smp_vld <= mul_vld;
    end
  end

endmodule

`default_nettype wire

/* logic/gen_regs.sv */
// waveform generator register block
// AXI4-Lite slave with control, sticky status, irq mask, per-channel
// settings, and the write port into the channel waveform tables
`timescale 1ns/1ps
`default_nettype none

module gen_regs (
  input  logic                                bus,
  input  logic                                rst_n,
  // write address and data
  input  logic                                awvalid,
  input  gen_bus_pkg::addr_t                  awaddr,
  output logic                                awready,
  input  logic                                wvalid,
  input  gen_bus_pkg::data_t                  wdata,
  output logic                                wready,
  // write response
  output logic                                bvalid,
  input  logic                                bready,
  output gen_bus_pkg::resp_t                  bresp,
  // read address and data
  input  logic                                arvalid,
  input  gen_bus_pkg::addr_t                  araddr,
  output logic                                arready,
  output logic                                rvalid,
  output gen_bus_pkg::data_t                  rdata,
  output gen_bus_pkg::resp_t                  rresp,
  input  logic                                rready,
  // channel side
  input  logic    [gen_dsp_pkg::NCH-1:0]      done,
  output logic    [gen_dsp_pkg::NCH-1:0]      run,
  output gen_dsp_pkg::phase_t                 step   [gen_dsp_pkg::NCH],
  output gen_dsp_pkg::phase_t                 phase0 [gen_dsp_pkg::NCH],
  output gen_dsp_pkg::gain_t                  gain   [gen_dsp_pkg::NCH],
  output gen_dsp_pkg::sample_t                dc     [gen_dsp_pkg::NCH],
  output gen_dsp_pkg::cycles_t                cycles [gen_dsp_pkg::NCH],
  // shared table write port
  output logic    [gen_dsp_pkg::NCH-1:0]      tbl_we,
  output gen_dsp_pkg::tbl_addr_t              tbl_addr,
  output gen_dsp_pkg::sample_t                tbl_data,
  output logic                                irq
);
  import gen_bus_pkg::*;
  import gen_dsp_pkg::*;

  // word aligned addresses
  addr_t          wa;
  addr_t          ra;
  logic           wr_acc;
  logic           rd_acc;
  // sticky done bits and interrupt mask
  logic [NCH-1:0] stat;
  logic [NCH-1:0] irq_en;
  data_t          rd_mux;

  // offset of an address inside channel c's register block
  function automatic addr_t ch_off(addr_t a, int c);
    return addr_t'(a - addr_t'(CH_BASE + c * CH_STRIDE));
  endfunction

  // offset inside channel c's table window
  function automatic addr_t tbl_off(addr_t a, int c);
    return addr_t'(a - addr_t'(TBL_BASE + c * TBL_STRIDE));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////////////////////////

  assign wa = {awaddr[ADDR_W-1:2], 2'b00};
  assign ra = {araddr[ADDR_W-1:2], 2'b00};

  // write needs both channels and no pending response
  assign wr_acc  = awvalid & wvalid & ~bvalid;
  assign awready = wr_acc;
  assign wready  = wr_acc;
  assign rd_acc  = arvalid & ~rvalid;
  assign arready = rd_acc;

  assign bresp = RESP_OKAY;
  assign rresp = RESP_OKAY;

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      // hold until the master takes it
      if (wr_acc)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
      if (rd_acc)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // table write port, lands with the register writes
  //////////////////////////////////////////////////////////////////////

  // table windows are aligned, so the low address bits pick the entry
  assign tbl_addr = wa[TBL_AW+1:2];
  assign tbl_data = sample_t'(wdata);

  always_comb begin
    for (int c = 0; c < NCH; c++) begin
      tbl_we[c] = wr_acc && (tbl_off(wa, c) < TBL_STRIDE);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // register writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      run    <= '0;
      stat   <= '0;
      irq_en <= '0;
      irq    <= 1'b0;
      for (int c = 0; c < NCH; c++) begin
        step[c]   <= '0;
        phase0[c] <= '0;
        gain[c]   <= '0;
        dc[c]     <= '0;
        cycles[c] <= '0;
      end
    end else begin
      // a finished burst drops its enable, even against a write
      if (wr_acc && wa == REG_CTRL)
        run <= wdata[NCH-1:0] & ~done;
      else
        run <= run & ~done;
      // write 1 to clear, new done wins
      if (wr_acc && wa == REG_STAT)
        stat <= (stat & ~wdata[NCH-1:0]) | done;
      else
        stat <= stat | done;
      if (wr_acc && wa == REG_IRQ_EN)
        irq_en <= wdata[NCH-1:0];
      // per-channel settings
      for (int c = 0; c < NCH; c++) begin
        if (wr_acc && ch_off(wa, c) < CH_STRIDE) begin
          case (ch_off(wa, c))
            CH_STEP:  step[c]   <= phase_t'(wdata);
            CH_PHASE: phase0[c] <= phase_t'(wdata);
            CH_GAIN:  gain[c]   <= gain_t'(wdata);
            CH_DC:    dc[c]     <= sample_t'(wdata);
            CH_CYC:   cycles[c] <= cycles_t'(wdata);
            default: ;
          endcase
        end
      end
      // registered interrupt
      irq <= |(stat & irq_en);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read mux, fields zero extended
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_mux = '0;
    case (ra)
      REG_CTRL:   rd_mux = data_t'(run);
      REG_STAT:   rd_mux = data_t'(stat);
      REG_IRQ_EN: rd_mux = data_t'(irq_en);
      default: ;
    endcase
    for (int c = 0; c < NCH; c++) begin
      if (ch_off(ra, c) < CH_STRIDE) begin
        case (ch_off(ra, c))
          CH_STEP:  rd_mux = data_t'(step[c]);
          CH_PHASE: rd_mux = data_t'(phase0[c]);
          // signed fields, no sign extension on readback
          CH_GAIN:  rd_mux = data_t'($unsigned(gain[c]));
          CH_DC:    rd_mux = data_t'($unsigned(dc[c]));
          CH_CYC:   rd_mux = data_t'(cycles[c]);
          default: ;
        endcase
      end
    end
  end

  // read data held with rvalid
  always_ff @(posedge bus) begin
    if (rd_acc)
      rdata <= rd_mux;
  end

endmodule

`default_nettype wire

/* logic/gen_dsp_pkg.sv */
// waveform generator datapath definitions
// channel count, table and phase geometry, sample and gain formats
`default_nettype none

package gen_dsp_pkg;

  localparam int NCH     = 2;
  // table index bits and phase fraction bits
  localparam int TBL_AW  = 4;
  localparam int PH_FW   = 8;
  localparam int PH_W    = TBL_AW + PH_FW;
  // sample and gain formats, gain is Q1.14
  localparam int SMP_W   = 14;
  localparam int GAIN_W  = 16;
  localparam int GAIN_FW = 14;
  localparam int CYC_W   = 16;
  // product after the fraction shift, then one guard bit for dc
  localparam int MUL_W   = SMP_W + GAIN_W - GAIN_FW;
  localparam int ACC_W   = MUL_W + 1;
  // mixer sum width
  localparam int MIX_W   = SMP_W + $clog2(NCH);

  typedef logic        [PH_W-1:0]   phase_t;
  typedef logic        [TBL_AW-1:0] tbl_addr_t;
  typedef logic signed [SMP_W-1:0]  sample_t;
  typedef logic signed [GAIN_W-1:0] gain_t;
  typedef logic        [CYC_W-1:0]  cycles_t;

  // saturation limits of the DAC range
  localparam sample_t SMP_MAX = sample_t'(2**(SMP_W-1) - 1);
  localparam sample_t SMP_MIN = sample_t'(-(2**(SMP_W-1)));

endpackage

`default_nettype wire

/* logic/gen_bus_pkg.sv */
// waveform generator bus side definitions
// AXI4-Lite address and data types, response codes and the register map
`default_nettype none

package gen_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////////////////////////

  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [1:0]        resp_t;

  // only OKAY is ever returned
  localparam resp_t RESP_OKAY = 2'b00;

  //////////////////////////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////////////////////////

  // global control and status
  localparam addr_t REG_CTRL   = 12'h000;
  localparam addr_t REG_STAT   = 12'h004;
  localparam addr_t REG_IRQ_EN = 12'h008;

  // per-channel register block
  localparam addr_t CH_BASE    = 12'h020;
  localparam addr_t CH_STRIDE  = 12'h020;
  // offsets inside one channel block
  localparam addr_t CH_STEP    = 12'h000;
  localparam addr_t CH_PHASE   = 12'h004;
  localparam addr_t CH_GAIN    = 12'h008;
  localparam addr_t CH_DC      = 12'h00c;
  localparam addr_t CH_CYC     = 12'h010;

  // waveform tables, one word per entry
  localparam addr_t TBL_BASE   = 12'h100;
  localparam addr_t TBL_STRIDE = 12'h040;

endpackage

`default_nettype wire
